//--- source/gfx_pkg.sv
`default_nettype none

package gfx_pkg;

  // colour and meta widths of one stored pixel
  localparam int COLOR_BITS = 4;
  localparam int META_BITS  = 4;
  localparam int PIXEL_BITS = 3 * COLOR_BITS;

  typedef logic [COLOR_BITS-1:0] color_t;
  typedef logic [META_BITS-1:0] meta_t;

  // red in the top bits, meta in the bottom bits
  typedef struct packed {
    color_t red;
    color_t grn;
    color_t blu;
    meta_t  meta;
  } fb_word_t;

  // default raster geometry
  localparam int DEF_H_VISIBLE = 16;
  localparam int DEF_V_VISIBLE = 8;
  localparam int DEF_H_BLANK   = 4;
  localparam int DEF_V_BLANK   = 2;

  // producer hold-off after a swap request, in cycles
  localparam int DEF_SWITCH_HOLD = 8;

endpackage

`default_nettype wire

//--- source/gfx_write_decode.sv
`timescale 1ns/1ns
`default_nettype none

module gfx_write_decode #(
  parameter int H_VISIBLE   = gfx_pkg::DEF_H_VISIBLE,
  parameter int V_VISIBLE   = gfx_pkg::DEF_V_VISIBLE,
  parameter int SWITCH_HOLD = gfx_pkg::DEF_SWITCH_HOLD,

  localparam int X_BITS    = $clog2(H_VISIBLE) + 1,
  localparam int Y_BITS    = $clog2(V_VISIBLE) + 1,
  localparam int ADDR_BITS = $clog2(H_VISIBLE * V_VISIBLE)
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [X_BITS-1:0]              gfx_x,
  input  logic [Y_BITS-1:0]              gfx_y,
  input  logic [gfx_pkg::PIXEL_BITS-1:0] gfx_color,
  input  gfx_pkg::meta_t                 gfx_meta,
  input  logic                           gfx_valid,
  input  logic                           mem_switch,
  output logic                           gfx_ready,
  output logic                           wr_en,
  output logic [ADDR_BITS-1:0]           wr_addr,
  output gfx_pkg::fb_word_t              wr_data,
  output logic                           swap
);
  import gfx_pkg::*;

  localparam int HOLD_BITS = (SWITCH_HOLD > 1) ? $clog2(SWITCH_HOLD) : 1;

  logic                 mem_switch_q;
  logic                 switch_rise;
  logic                 holding;
  logic [HOLD_BITS-1:0] hold_cnt;
  logic                 hold_last;
  logic                 accept;
  logic                 in_range;
  logic [ADDR_BITS-1:0] lin_addr;

  assign switch_rise = mem_switch && !mem_switch_q;
  assign hold_last   = holding && (hold_cnt == HOLD_BITS'(SWITCH_HOLD - 1));

  // producer is held off for the whole swap window
  assign gfx_ready = !holding;
  assign swap      = hold_last;

  assign accept   = gfx_valid && gfx_ready;
  assign in_range = (int'(gfx_x) < H_VISIBLE) && (int'(gfx_y) < V_VISIBLE);
  assign lin_addr = ADDR_BITS'(int'(gfx_y) * H_VISIBLE + int'(gfx_x));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_switch_q <= 1'b0;
    end else begin
      mem_switch_q <= mem_switch;
    end
  end

  // a new rising edge only starts a hold when none is running
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      holding  <= 1'b0;
      hold_cnt <= '0;
    end else if (!holding) begin
      if (switch_rise) begin
        holding  <= 1'b1;
        hold_cnt <= '0;
      end
    end else if (hold_last) begin
      holding <= 1'b0;
    end else begin
      hold_cnt <= hold_cnt + 1'b1;
    end
  end

  // off-screen pixels are accepted but never reach the memory
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= accept && in_range;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wr_addr      <= lin_addr;
      wr_data.red  <= gfx_color[3*COLOR_BITS-1 -: COLOR_BITS];
      wr_data.grn  <= gfx_color[2*COLOR_BITS-1 -: COLOR_BITS];
      wr_data.blu  <= gfx_color[COLOR_BITS-1:0];
      wr_data.meta <= gfx_meta;
    end
  end

endmodule

`default_nettype wire

//--- source/fb_dbuf_memory.sv
`timescale 1ns/1ns
`default_nettype none

module fb_dbuf_memory #(
  parameter int H_VISIBLE = gfx_pkg::DEF_H_VISIBLE,
  parameter int V_VISIBLE = gfx_pkg::DEF_V_VISIBLE,

  localparam int ADDR_BITS = $clog2(H_VISIBLE * V_VISIBLE)
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wr_en,
  input  logic [ADDR_BITS-1:0] wr_addr,
  input  gfx_pkg::fb_word_t    wr_data,
  input  logic                 swap,
  input  logic [ADDR_BITS-1:0] rd_addr,
  output gfx_pkg::fb_word_t    rd_data
);
  import gfx_pkg::*;

  localparam int DEPTH = H_VISIBLE * V_VISIBLE;

  fb_word_t bank0_mem [DEPTH];
  fb_word_t bank1_mem [DEPTH];

  // 0 means bank 0 is on screen
  logic     front_sel;
  logic     wr_bank0;
  logic     wr_bank1;
  fb_word_t rd_bank0;
  fb_word_t rd_bank1;

  // writes always land in the back bank
  assign wr_bank0 = wr_en && front_sel;
  assign wr_bank1 = wr_en && !front_sel;

  // the old select still applies to a write on the swap edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      front_sel <= 1'b0;
    end else if (swap) begin
      front_sel <= !front_sel;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_bank0) begin
      bank0_mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_bank1) begin
      bank1_mem[wr_addr] <= wr_data;
    end
  end

  assign rd_bank0 = bank0_mem[rd_addr];
  assign rd_bank1 = bank1_mem[rd_addr];

  // one cycle read latency from the front bank
  always_ff @(posedge clk) begin
    rd_data <= front_sel ? rd_bank1 : rd_bank0;
  end

endmodule

`default_nettype wire

//--- source/vga_pixel_stream.sv
`timescale 1ns/1ns
`default_nettype none

module vga_pixel_stream #(
  parameter int H_VISIBLE = gfx_pkg::DEF_H_VISIBLE,
  parameter int V_VISIBLE = gfx_pkg::DEF_V_VISIBLE,
  parameter int H_BLANK   = gfx_pkg::DEF_H_BLANK,
  parameter int V_BLANK   = gfx_pkg::DEF_V_BLANK,

  localparam int ADDR_BITS = $clog2(H_VISIBLE * V_VISIBLE)
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 vga_enable,
  input  gfx_pkg::fb_word_t    rd_data,
  output logic [ADDR_BITS-1:0] rd_addr,
  output gfx_pkg::color_t      vga_red,
  output gfx_pkg::color_t      vga_grn,
  output gfx_pkg::color_t      vga_blu,
  output gfx_pkg::meta_t       vga_meta,
  output logic                 vga_valid,
  output logic                 vga_hsync,
  output logic                 vga_vsync,
  output logic                 frame_start
);
  import gfx_pkg::*;

  localparam int H_TOTAL = H_VISIBLE + H_BLANK;
  localparam int V_TOTAL = V_VISIBLE + V_BLANK;
  localparam int H_BITS  = $clog2(H_TOTAL);
  localparam int V_BITS  = $clog2(V_TOTAL);

  logic [H_BITS-1:0]    h_cnt;
  logic [V_BITS-1:0]    v_cnt;
  logic [ADDR_BITS-1:0] addr_cnt;
  logic                 h_last;
  logic                 v_last;
  logic                 visible;
  logic                 hsync_win;
  logic                 vsync_win;

  // first pipeline stage, in step with the memory read
  logic                 s1_valid;
  logic                 s1_hsync;
  logic                 s1_vsync;
  logic                 s1_frame;
  fb_word_t             pix_q;

  assign h_last  = (h_cnt == H_BITS'(H_TOTAL - 1));
  assign v_last  = (v_cnt == V_BITS'(V_TOTAL - 1));
  assign visible = (int'(h_cnt) < H_VISIBLE) && (int'(v_cnt) < V_VISIBLE);

  // hsync covers the first two blank positions of each line
  assign hsync_win = (int'(h_cnt) >= H_VISIBLE) && (int'(h_cnt) < H_VISIBLE + 2);
  assign vsync_win = (int'(v_cnt) == V_VISIBLE);

  assign rd_addr = addr_cnt;

  // raster counters and the running read address only move when enabled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt    <= '0;
      v_cnt    <= '0;
      addr_cnt <= '0;
    end else if (vga_enable) begin
      if (h_last) begin
        h_cnt <= '0;
        v_cnt <= v_last ? '0 : v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
      if (h_last && v_last) begin
        addr_cnt <= '0;
      end else if (visible) begin
        addr_cnt <= addr_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid    <= 1'b0;
      s1_hsync    <= 1'b0;
      s1_vsync    <= 1'b0;
      s1_frame    <= 1'b0;
      vga_valid   <= 1'b0;
      vga_hsync   <= 1'b0;
      vga_vsync   <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      s1_valid    <= visible && vga_enable;
      s1_hsync    <= hsync_win;
      s1_vsync    <= vsync_win;
      s1_frame    <= visible && vga_enable && (h_cnt == '0) && (v_cnt == '0);
      vga_valid   <= s1_valid;
      vga_hsync   <= s1_hsync;
      vga_vsync   <= s1_vsync;
      frame_start <= s1_frame;
    end
  end

  always_ff @(posedge clk) begin
    pix_q <= rd_data;
  end

  // blank pixels are driven as black
  assign vga_red  = vga_valid ? pix_q.red : '0;
  assign vga_grn  = vga_valid ? pix_q.grn : '0;
  assign vga_blu  = vga_valid ? pix_q.blu : '0;
  assign vga_meta = vga_valid ? pix_q.meta : '0;

endmodule

`default_nettype wire

//--- source/gfx_dbuf.sv
`timescale 1ns/1ns
`default_nettype none

module gfx_dbuf #(
  parameter int H_VISIBLE   = gfx_pkg::DEF_H_VISIBLE,
  parameter int V_VISIBLE   = gfx_pkg::DEF_V_VISIBLE,
  parameter int H_BLANK     = gfx_pkg::DEF_H_BLANK,
  parameter int V_BLANK     = gfx_pkg::DEF_V_BLANK,
  parameter int SWITCH_HOLD = gfx_pkg::DEF_SWITCH_HOLD,

  localparam int X_BITS    = $clog2(H_VISIBLE) + 1,
  localparam int Y_BITS    = $clog2(V_VISIBLE) + 1,
  localparam int ADDR_BITS = $clog2(H_VISIBLE * V_VISIBLE)
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           mem_switch,
  input  logic [X_BITS-1:0]              gfx_x,
  input  logic [Y_BITS-1:0]              gfx_y,
  input  logic [gfx_pkg::PIXEL_BITS-1:0] gfx_color,
  input  gfx_pkg::meta_t                 gfx_meta,
  input  logic                           gfx_valid,
  output logic                           gfx_ready,
  output logic                           gfx_vsync,
  input  logic                           vga_enable,
  output gfx_pkg::color_t                vga_red,
  output gfx_pkg::color_t                vga_grn,
  output gfx_pkg::color_t                vga_blu,
  output gfx_pkg::meta_t                 vga_meta,
  output logic                           vga_valid,
  output logic                           vga_hsync,
  output logic                           vga_vsync
);
  import gfx_pkg::*;

  // producer write path
  logic                 wr_en;
  logic [ADDR_BITS-1:0] wr_addr;
  fb_word_t             wr_data;
  logic                 swap;

  // scan-out read path
  logic [ADDR_BITS-1:0] rd_addr;
  fb_word_t             rd_data;

  gfx_write_decode #(
    .H_VISIBLE  (H_VISIBLE),
    .V_VISIBLE  (V_VISIBLE),
    .SWITCH_HOLD(SWITCH_HOLD)
  ) gfx_write_decode_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .gfx_x     (gfx_x),
    .gfx_y     (gfx_y),
    .gfx_color (gfx_color),
    .gfx_meta  (gfx_meta),
    .gfx_valid (gfx_valid),
    .mem_switch(mem_switch),
    .gfx_ready (gfx_ready),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .swap      (swap)
  );

  fb_dbuf_memory #(
    .H_VISIBLE(H_VISIBLE),
    .V_VISIBLE(V_VISIBLE)
  ) fb_dbuf_memory_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .swap   (swap),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  // frame start goes back to the producer as its vsync
  vga_pixel_stream #(
    .H_VISIBLE(H_VISIBLE),
    .V_VISIBLE(V_VISIBLE),
    .H_BLANK  (H_BLANK),
    .V_BLANK  (V_BLANK)
  ) vga_pixel_stream_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .vga_enable (vga_enable),
    .rd_data    (rd_data),
    .rd_addr    (rd_addr),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_meta   (vga_meta),
    .vga_valid  (vga_valid),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .frame_start(gfx_vsync)
  );

endmodule

`default_nettype wire

//--- testbench/gfx_dbuf_tb.sv
`timescale 1ns/1ns
`default_nettype none

module gfx_dbuf_tb;
  import gfx_pkg::*;

  localparam int H_VIS   = DEF_H_VISIBLE;
  localparam int V_VIS   = DEF_V_VISIBLE;
  localparam int HOLD    = DEF_SWITCH_HOLD;
  localparam int DEPTH   = H_VIS * V_VIS;
  localparam int V_TOTAL = V_VIS + DEF_V_BLANK;
  localparam int X_BITS  = $clog2(H_VIS) + 1;
  localparam int Y_BITS  = $clog2(V_VIS) + 1;
  localparam int FRAME_CYCLES = (H_VIS + DEF_H_BLANK) * V_TOTAL;
  // 12 frames of scan-out plus the producer writes
  localparam int TIMEOUT_CYCLES = 12 * FRAME_CYCLES + 600;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  mem_switch;
  logic [X_BITS-1:0]     gfx_x;
  logic [Y_BITS-1:0]     gfx_y;
  logic [PIXEL_BITS-1:0] gfx_color;
  meta_t                 gfx_meta;
  logic                  gfx_valid;
  logic                  gfx_ready;
  logic                  gfx_vsync;
  logic                  vga_enable;
  color_t                vga_red;
  color_t                vga_grn;
  color_t                vga_blu;
  meta_t                 vga_meta;
  logic                  vga_valid;
  logic                  vga_hsync;
  logic                  vga_vsync;

  // reference model of the two banks and the swap sequencing
  logic [15:0] model_mem [2][DEPTH];
  bit          model_known [2][DEPTH];
  bit          front, front_d1, front_d2, sw_q, pend_en;
  int          hold_left, pend_addr, scan_ptr, scan_idx;
  logic [15:0] pend_word, exp_word;
  bit          exp_known, exp_ready;
  int          valid_cnt, hs_windows, vs_windows, hs_en_cnt;
  bit          frame_seen, hs_prev, vs_prev, en_d1, en_d2, pause_mode;
  int          value_errs, other_errs, pix_checked, cycle_cnt;
  logic [31:0] rng_state;

  always #5 clk = ~clk;

  gfx_dbuf #(
    .H_VISIBLE  (H_VIS),
    .V_VISIBLE  (V_VIS),
    .H_BLANK    (DEF_H_BLANK),
    .V_BLANK    (DEF_V_BLANK),
    .SWITCH_HOLD(HOLD)
  ) gfx_dbuf_inst (
    .clk(clk), .rst_n(rst_n), .mem_switch(mem_switch),
    .gfx_x(gfx_x), .gfx_y(gfx_y), .gfx_color(gfx_color), .gfx_meta(gfx_meta),
    .gfx_valid(gfx_valid), .gfx_ready(gfx_ready), .gfx_vsync(gfx_vsync),
    .vga_enable(vga_enable), .vga_red(vga_red), .vga_grn(vga_grn), .vga_blu(vga_blu),
    .vga_meta(vga_meta), .vga_valid(vga_valid), .vga_hsync(vga_hsync), .vga_vsync(vga_vsync)
  );

  // outputs describe the read two edges back, so the front index is delayed twice
  assign scan_idx  = (gfx_vsync ? 0 : scan_ptr) % DEPTH;
  assign exp_word  = model_mem[front_d2][scan_idx];
  assign exp_known = model_known[front_d2][scan_idx];
  assign exp_ready = (hold_left == 0);

  always @(posedge clk) begin
    if (!rst_n) begin
      front      = 0;
      front_d1   = 0;
      front_d2   = 0;
      sw_q       = 0;
      pend_en    = 0;
      hold_left  = 0;
      scan_ptr   = 0;
      valid_cnt  = 0;
      hs_windows = 0;
      vs_windows = 0;
      hs_en_cnt  = 0;
      frame_seen = 0;
      hs_prev    = 0;
      vs_prev    = 0;
      en_d1      = 0;
      en_d2      = 0;
    end else begin
      if (gfx_vsync) begin
        frame_seen = 1'b1;
        valid_cnt  = 0;
        hs_windows = 0;
        vs_windows = 0;
      end
      if (vga_valid) begin
        valid_cnt++;
        if (exp_known) pix_checked++;
        scan_ptr = scan_idx + 1;
      end
      if (hs_prev && !vga_hsync) begin
        hs_windows++;
        hs_en_cnt = 0;
      end
      if (vga_hsync && en_d2) hs_en_cnt++;
      if (vga_vsync && !vs_prev) vs_windows++;
      hs_prev = vga_hsync;
      vs_prev = vga_vsync;
      en_d2   = en_d1;
      en_d1   = vga_enable;
      // an accepted pixel reaches the back bank one edge later
      if (pend_en) begin
        model_mem[!front][pend_addr]   = pend_word;
        model_known[!front][pend_addr] = 1'b1;
      end
      pend_en   = gfx_valid && exp_ready && (gfx_x < H_VIS) && (gfx_y < V_VIS);
      pend_addr = int'(gfx_y) * H_VIS + int'(gfx_x);
      pend_word = {gfx_color, gfx_meta};
      front_d2  = front_d1;
      front_d1  = front;
      if (hold_left > 0) begin
        hold_left--;
        if (hold_left == 0) front = !front;
      end else if (mem_switch && !sw_q) begin
        hold_left = HOLD;
      end
      sw_q = mem_switch;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) gfx_ready == exp_ready)
    else begin
      value_errs++;
      $display("[ERROR] %0t: gfx_ready is %b, expected %b", $time,
               $sampled(gfx_ready), $sampled(exp_ready));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    (vga_valid && exp_known) |-> ({vga_red, vga_grn, vga_blu, vga_meta} == exp_word))
    else begin
      value_errs++;
      $display("[ERROR] %0t: pixel %0d shows %h, expected %h", $time, $sampled(scan_idx),
               $sampled({vga_red, vga_grn, vga_blu, vga_meta}), $sampled(exp_word));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    !vga_valid |-> ({vga_red, vga_grn, vga_blu, vga_meta} == '0))
    else begin
      value_errs++;
      $display("[ERROR] %0t: blank output is %h, expected 0", $time,
               $sampled({vga_red, vga_grn, vga_blu, vga_meta}));
    end

  assert property (@(posedge clk) disable iff (!rst_n) vga_valid |-> en_d2)
    else begin
      value_errs++;
      $display("[ERROR] %0t: vga_valid is 1 for a paused cycle, expected 0", $time);
    end

  // the frame pulse sits on the first visible pixel of a frame
  assert property (@(posedge clk) disable iff (!rst_n)
    gfx_vsync |-> (vga_valid && (scan_ptr % DEPTH == 0)))
    else begin
      value_errs++;
      $display("[ERROR] %0t: gfx_vsync with vga_valid %b at pixel %0d, expected valid pixel 0",
               $time, $sampled(vga_valid), $sampled(scan_ptr % DEPTH));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    (gfx_vsync && frame_seen) |-> (valid_cnt == DEPTH))
    else begin
      value_errs++;
      $display("[ERROR] %0t: frame had %0d valid pixels, expected %0d", $time,
               $sampled(valid_cnt), DEPTH);
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    (gfx_vsync && frame_seen) |-> (hs_windows == V_TOTAL && vs_windows == 1))
    else begin
      value_errs++;
      $display("[ERROR] %0t: frame had %0d hsync and %0d vsync windows, expected %0d and 1",
               $time, $sampled(hs_windows), $sampled(vs_windows), V_TOTAL);
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    (hs_prev && !vga_hsync) |-> (hs_en_cnt == 2))
    else begin
      value_errs++;
      $display("[ERROR] %0t: hsync window was %0d cycles, expected 2", $time,
               $sampled(hs_en_cnt));
    end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs + 1);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  task automatic next_random(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // inputs change 1 ns after the rising edge
  task automatic step();
    logic [31:0] r;
    @(posedge clk);
    #1;
    if (pause_mode) begin
      next_random(r);
      // roughly one cycle in four is paused
      vga_enable = (r[1:0] != 2'b00);
    end
  endtask

  task automatic drive_random_pixel(input int x, input int y);
    logic [31:0] r;
    next_random(r);
    gfx_x     = X_BITS'(x);
    gfx_y     = Y_BITS'(y);
    gfx_color = r[PIXEL_BITS-1:0];
    gfx_meta  = r[PIXEL_BITS +: META_BITS];
    gfx_valid = 1'b1;
  endtask

  task automatic write_pixel(input int x, input int y);
    while (!gfx_ready) step();
    drive_random_pixel(x, y);
    step();
    gfx_valid = 1'b0;
  endtask

  task automatic fill_bank();
    for (int y = 0; y < V_VIS; y++) begin
      for (int x = 0; x < H_VIS; x++) begin
        write_pixel(x, y);
      end
    end
  endtask

  task automatic write_random(input int count);
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
      next_random(r);
      // about one write in eight lands off screen
      write_pixel((r % H_VIS) + ((r[20:18] == 0) ? H_VIS : 0), (r >> 8) % V_VIS);
    end
  endtask

  // the producer keeps pushing during the hold, and mem_switch rises a second time
  task automatic request_swap();
    mem_switch = 1'b1;
    step();
    for (int i = 0; i <= HOLD; i++) begin
      drive_random_pixel(i % H_VIS, i % V_VIS);
      mem_switch = (i != 2);
      step();
    end
    gfx_valid  = 1'b0;
    mem_switch = 1'b0;
    while (!gfx_ready) step();
  endtask

  task automatic wait_frames(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      step();
      if (gfx_vsync) seen++;
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    mem_switch = 1'b0;
    gfx_x      = '0;
    gfx_y      = '0;
    gfx_color  = '0;
    gfx_meta   = '0;
    gfx_valid  = 1'b0;
    vga_enable = 1'b1;
    rng_state  = 32'hfef4_c4e0;
    pause_mode = 1'b0;
    value_errs = 0;
    other_errs = 0;
    pix_checked = 0;
    cycle_cnt  = 0;
    repeat (4) step();
    rst_n = 1'b1;
    assert (!vga_valid && !vga_hsync && !vga_vsync && !gfx_vsync && gfx_ready)
      else begin
        value_errs++;
        $display("[ERROR] %0t: outputs after reset are not at their reset values", $time);
      end

    // bank 1 is the back bank after reset
    fill_bank();
    write_pixel(H_VIS + 4, 0);
    write_pixel(3, V_VIS + 1);
    write_pixel(2 * H_VIS - 1, 2 * V_VIS - 1);
    request_swap();
    wait_frames(2);

    // bank 0 fills while bank 1 is on screen
    fill_bank();
    request_swap();
    wait_frames(2);
    request_swap();
    wait_frames(2);

    pause_mode = 1'b1;
    write_random(40);
    request_swap();
    wait_frames(2);
    pause_mode = 1'b0;
    vga_enable = 1'b1;
    repeat (3) step();

    if (pix_checked < 4 * DEPTH) begin
      other_errs++;
      $display("too few displayed pixels were compared: %0d", pix_checked);
    end
    $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- gfx_dbuf.f
source/gfx_pkg.sv
source/gfx_write_decode.sv
source/fb_dbuf_memory.sv
source/vga_pixel_stream.sv
source/gfx_dbuf.sv
testbench/gfx_dbuf_tb.sv
